// ==== bench/benchMemory.sv ====
`timescale 1ns/10ps

module benchMemory #(
  parameter logic [17:0] tableBase = 18'h0
) (
  input  logic        clk,
  input  logic        walkReq,
  input  logic [31:0] walkAdr,
  output logic        walkReady,
  output logic [31:0] walkData
);

  localparam logic [31:0] firstBase  = {tableBase, 14'b0};  // 16 KB aligned L1 table
  localparam logic [31:0] coarseBase = 32'h0005_0000;       // 1 KB aligned L2 table

  logic [31:0] words [logic [31:0]];  // Sparse map where unset words read as fault
  logic        reading;               // Read accepted and wait states running
  int unsigned waitLeft;

  initial begin
    void'($urandom(32'h14b4d52b));
    walkReady = 1'b0;
    walkData  = '0;
    reading   = 1'b0;
    waitLeft  = 0;
    // ========================================
    // Page table image
    // ========================================
    words[firstBase + 32'h4]  = 32'h8000_0C02;        // VA 001 maps section 800 with AP 11 in dom 0
    words[firstBase + 32'h8]  = coarseBase | 32'h21;  // VA 002 points at coarse table in dom 1
    words[firstBase + 32'hC]  = 32'h0000_0000;        // VA 003 is a fault entry
    words[coarseBase + 32'hC] = 32'h9001_2632;        // Small page with subpage AP 01 10 00 11
    // Large page spans 16 slots
    for (int i = 'h40; i < 'h50; i++) begin
      words[coarseBase + 32'(4 * i)] = 32'hA005_0031;  // Subpage 0 AP 11 and others 00
    end
    // ========================================
    // Read port with 0 to 3 wait states
    // ========================================
    forever begin
      @(negedge clk);
      if (walkReady) begin
        walkReady = 1'b0;  // One-cycle strobe
      end else if (walkReq) begin
        if (!reading) begin
          reading  = 1'b1;
          waitLeft = $urandom % 4;
        end
        if (waitLeft == 0) begin
          walkData  = words.exists(walkAdr) ? words[walkAdr] : 32'h0;
          walkReady = 1'b1;
          reading   = 1'b0;
        end else begin
          waitLeft--;
        end
      end
    end
  end

endmodule

// ==== bench/mmuBench.sv ====
`timescale 1ns/10ps

module mmuBench;

  localparam logic [mmuPkg::tableBaseBits-1:0] tableBaseVal = 18'h00010;  // L1 at 0x0004_0000
  localparam int timeoutCycles = 6 * 20 * 16 + 80;  // Tests x translations x cycles plus reset

  // Addresses mapped by the table in benchMemory
  localparam logic [31:0] sectionVa  = 32'h0011_2345;
  localparam logic [31:0] smallVa0   = 32'h0020_3123;  // Subpage 0 with AP 11
  localparam logic [31:0] smallVa1   = 32'h0020_3456;  // Subpage 1 with AP 00
  localparam logic [31:0] smallVa2   = 32'h0020_3856;  // Subpage 2 with AP 10
  localparam logic [31:0] largeVa0   = 32'h0024_1234;  // Subpage 0 with AP 11
  localparam logic [31:0] largeVa3   = 32'h0024_C010;  // Subpage 3 with AP 00
  localparam logic [31:0] faultVa    = 32'h0030_0ABC;
  localparam logic [11:0] sectionBase = 12'h800;
  localparam logic [19:0] smallFrame  = 20'h90012;
  localparam logic [15:0] largeFrame  = 16'hA005;

  logic                             clk, reset, request, write, privileged;
  logic                             mmuEnable, tlbFlush, done, abort, walkReq, walkReady;
  logic [mmuPkg::tableBaseBits-1:0] tableBase;
  logic [31:0]                      virtAdr, domainAccess, physAdr, walkAdr, walkData;
  logic [faultPkg::fsrBits-1:0]     fsr;
  logic [faultPkg::farBits-1:0]     far;
  logic [31:0]                      firstWalkAdr;  // First table read of the last request
  logic [31:0]                      lastWalkAdr;   // Final table read of the last request
  string                            testName;
  int                               testErrors, errorCount, testsRun, testsFailed;
  int                               cycleCount = 0;

  mmuTop #(.tlbEntries(4)) u_dut (
    .clk, .reset, .request, .virtAdr, .write, .privileged, .mmuEnable, .tableBase,
    .domainAccess, .tlbFlush, .walkReady, .walkData, .done, .abort, .physAdr,
    .walkReq, .walkAdr, .fsr, .far
  );

  benchMemory #(.tableBase(tableBaseVal)) u_memory (
    .clk, .walkReq, .walkAdr, .walkReady, .walkData
  );

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount >= timeoutCycles) begin
      $display("Timeout after %0d cycles, a translation never finished", cycleCount);
      $display("Errors found");
      $finish;
    end
  end

  // ========================================
  // Compare tasks
  // ========================================
  task automatic checkAddress(input string label, input logic [31:0] expected,
                              input logic [31:0] actual);
    if (actual !== expected) begin
      $display("CHECK FAILED %s (%s): expected %h, actual %h", testName, label, expected, actual);
      testErrors++;
    end
  endtask

  task automatic checkFault(input string label, input faultPkg::faultCode expCode,
                            input logic [mmuPkg::domainBits-1:0] expDomain,
                            input logic [faultPkg::fsrBits-1:0] actual);
    if (actual[3:0] !== expCode || actual[7:4] !== expDomain) begin
      $display("CHECK FAILED %s (%s): expected fsr %h, actual %h", testName, label,
               {expDomain, expCode}, actual);
      testErrors++;
    end
  endtask

  task automatic checkCount(input string label, input int expected, input int actual);
    if (actual != expected) begin
      $display("CHECK FAILED %s (%s): expected %0d, actual %0d", testName, label, expected, actual);
      testErrors++;
    end
  endtask

  task automatic checkFlag(input string label, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("CHECK FAILED %s (%s): expected %b, actual %b", testName, label, expected, actual);
      testErrors++;
    end
  endtask

  // ========================================
  // CPU side requests
  // ========================================
  task automatic translate(input logic [31:0] va, input logic wr, input logic priv,
                           output logic gotDone, output logic [31:0] pa,
                           output int cycles, output logic walked);
    cycles       = 0;
    walked       = 1'b0;
    firstWalkAdr = '0;
    lastWalkAdr  = '0;
    @(negedge clk);  // Idle cycle between requests
    request    = 1'b1;
    virtAdr    = va;
    write      = wr;
    privileged = priv;
    do begin
      @(negedge clk);
      cycles++;
      if (walkReq && !walked) firstWalkAdr = walkAdr;
      if (walkReq) lastWalkAdr = walkAdr;
      walked = walked | walkReq;
    end while (!done && !abort);
    gotDone = done;
    pa      = physAdr;
    request = 1'b0;
  endtask

  task automatic expectDone(input string label, input logic [31:0] va, input logic wr,
                            input logic priv, input logic [31:0] expPa,
                            output int cycles, output logic walked);
    logic        gotDone;
    logic [31:0] pa;
    translate(va, wr, priv, gotDone, pa, cycles, walked);
    checkFlag({label, " done"}, 1'b1, gotDone);
    checkAddress(label, expPa, pa);
  endtask

  task automatic expectAbort(input string label, input logic [31:0] va, input logic wr,
                             input logic priv, input faultPkg::faultCode expCode,
                             input logic [mmuPkg::domainBits-1:0] expDomain);
    logic        gotDone;
    logic [31:0] pa;
    int          cycles;
    logic        walked;
    translate(va, wr, priv, gotDone, pa, cycles, walked);
    checkFlag({label, " abort"}, 1'b0, gotDone);
    @(negedge clk);  // FSR and FAR load on the edge after abort
    checkFault(label, expCode, expDomain, fsr);
    checkAddress({label, " far"}, va, far);
  endtask

  task automatic startTest(input string name);
    testName   = name;
    testErrors = 0;
  endtask

  task automatic finishTest();
    testsRun++;
    errorCount += testErrors;
    if (testErrors == 0) begin
      $display("Test %-10s PASS", testName);
    end else begin
      testsFailed++;
      $display("Test %-10s FAIL, %0d mismatches", testName, testErrors);
    end
  endtask

  // ========================================
  // Directed tests
  // ========================================
  task automatic testMmuOff();
    int   cycles;
    logic walked;
    startTest("mmuOff");
    checkFlag("idle after reset", 1'b0, done | abort | walkReq);
    checkFault("fsr after reset", faultPkg::faultNone, 4'h0, fsr);
    checkAddress("far after reset", 32'h0, far);
    mmuEnable = 1'b0;  // Identity map
    expectDone("identity", 32'h1234_5678, 1'b0, 1'b0, 32'h1234_5678, cycles, walked);
    checkCount("latency", 1, cycles);
    expectDone("identity write", 32'hFEDC_BA98, 1'b1, 1'b0, 32'hFEDC_BA98, cycles, walked);
    checkFlag("no walk", 1'b0, walked);
    finishTest();
  endtask

  task automatic testSection();
    int   cycles;
    logic walked;
    startTest("section");
    mmuEnable    = 1'b1;
    domainAccess = 32'h0000_0005;  // Domains 0 and 1 client
    expectDone("miss", sectionVa, 1'b0, 1'b0, {sectionBase, sectionVa[19:0]}, cycles, walked);
    checkFlag("miss walks", 1'b1, walked);
    checkAddress("l1 read", 32'h0004_0004, firstWalkAdr);  // Entry 1 of the L1 table
    expectDone("hit", sectionVa, 1'b0, 1'b0, {sectionBase, sectionVa[19:0]}, cycles, walked);
    checkCount("hit latency", 1, cycles);
    checkFlag("hit no walk", 1'b0, walked);
    finishTest();
  endtask

  task automatic testCoarse();
    int   cycles;
    logic walked;
    startTest("coarse");
    expectDone("small sub0", smallVa0, 1'b0, 1'b0, {smallFrame, smallVa0[11:0]}, cycles, walked);
    checkFlag("small walks", 1'b1, walked);
    checkAddress("small l2 read", 32'h0005_000C, lastWalkAdr);  // Slot 3 of the coarse table
    expectAbort("small sub1", smallVa1, 1'b0, 1'b0, faultPkg::permPage, 4'h1);
    expectDone("large sub0", largeVa0, 1'b0, 1'b0, {largeFrame, largeVa0[15:0]}, cycles, walked);
    checkAddress("large l2 read", 32'h0005_0104, lastWalkAdr);  // Slot 41 of the coarse table
    expectAbort("large sub3", largeVa3, 1'b0, 1'b0, faultPkg::permPage, 4'h1);
    finishTest();
  endtask

  task automatic testTransFault();
    startTest("transFault");
    expectAbort("fault entry", faultVa, 1'b0, 1'b1, faultPkg::transSection, 4'h0);
    finishTest();
  endtask

  task automatic testDomainAp();
    int   cycles;
    logic walked;
    startTest("domainAp");
    domainAccess = 32'h0000_0004;  // Domain 0 no access
    expectAbort("no access", sectionVa, 1'b0, 1'b1, faultPkg::domainSection, 4'h0);
    domainAccess = 32'h0000_000D;  // Domain 1 manager
    expectDone("manager ap00", smallVa1, 1'b1, 1'b0, {smallFrame, smallVa1[11:0]}, cycles, walked);
    domainAccess = 32'h0000_0005;
    expectAbort("user write ap10", smallVa2, 1'b1, 1'b0, faultPkg::permPage, 4'h1);
    expectDone("user read ap10", smallVa2, 1'b0, 1'b0, {smallFrame, smallVa2[11:0]}, cycles, walked);
    finishTest();
  endtask

  task automatic testFlush();
    int   cycles;
    logic walked;
    startTest("flush");
    expectDone("before", sectionVa, 1'b0, 1'b0, {sectionBase, sectionVa[19:0]}, cycles, walked);
    tlbFlush = 1'b1;
    @(negedge clk);
    tlbFlush = 1'b0;
    expectDone("after", sectionVa, 1'b0, 1'b0, {sectionBase, sectionVa[19:0]}, cycles, walked);
    checkFlag("walk after flush", 1'b1, walked);
    finishTest();
  endtask

  initial begin
    clk          = 1'b0;
    reset        = 1'b1;
    request      = 1'b0;
    virtAdr      = '0;
    write        = 1'b0;
    privileged   = 1'b0;
    mmuEnable    = 1'b0;
    tableBase    = tableBaseVal;
    domainAccess = '0;
    tlbFlush     = 1'b0;
    firstWalkAdr = '0;
    lastWalkAdr  = '0;
    testErrors   = 0;
    errorCount   = 0;
    testsRun     = 0;
    testsFailed  = 0;
    repeat (3) @(negedge clk);  // Three rising edges in reset
    reset = 1'b0;
    testMmuOff();
    testSection();
    testCoarse();
    testTransFault();
    testDomainAp();
    testFlush();
    $display("Summary: %0d tests run, %0d failed, %0d mismatches", testsRun, testsFailed,
             errorCount);
    if (errorCount == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// ==== compile.f ====
hdl/mmuPkg.sv
hdl/faultPkg.sv
hdl/translationTlb.sv
hdl/tableWalker.sv
hdl/accessCheck.sv
hdl/faultRegs.sv
hdl/mmuTop.sv
bench/benchMemory.sv
bench/mmuBench.sv

// ==== hdl/accessCheck.sv ====
`timescale 1ns/10ps

module accessCheck (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          lookupValid,
  input  logic                          hit,
  input  logic                          bypass,
  input  mmuPkg::pageSize               size,
  input  logic [mmuPkg::domainBits-1:0] domain,
  input  logic [mmuPkg::apBits-1:0]     ap,
  input  logic [mmuPkg::ppnBits-1:0]    physFrame,
  input  logic [31:0]                   virtAdr,
  input  logic                          privileged,
  input  logic                          write,
  input  logic [31:0]                   domainAccess,
  input  logic                          walkFault,
  input  faultPkg::faultCode            walkFaultCode,
  input  logic [mmuPkg::domainBits-1:0] walkDomain,
  output logic                          done,
  output logic                          abort,
  output logic [31:0]                   physAdr,
  output logic [faultPkg::fsrBits-1:0]  faultStatus
);

  localparam int frameTop = mmuPkg::ppnBits - 1;

  logic               hitValid;
  logic               isSection;
  logic               permOk;
  logic [1:0]         domField;
  faultPkg::faultCode hitCode;

  assign hitValid  = lookupValid & hit;
  assign isSection = (size == mmuPkg::sizeSection);
  assign domField  = domainAccess[2*domain +: 2];  // DACR field

  // AP rule, client domains only
  always_comb begin
    case (ap)
      2'b00:   permOk = 1'b0;
      2'b01:   permOk = privileged;
      2'b10:   permOk = privileged | ~write;  // User read only
      default: permOk = 1'b1;
    endcase
  end

  always_comb begin
    hitCode = faultPkg::faultNone;
    if (!bypass) begin
      case (domField)
        2'b11: hitCode = faultPkg::faultNone;  // Manager, no AP check
        2'b01: begin
          if (!permOk) hitCode = isSection ? faultPkg::permSection : faultPkg::permPage;
        end
        default: hitCode = isSection ? faultPkg::domainSection : faultPkg::domainPage;
      endcase
    end
  end

  // Frame plus page offset
  always_comb begin
    case (size)
      mmuPkg::sizeSection: physAdr = {physFrame[frameTop:10], virtAdr[19:0]};
      mmuPkg::sizeLarge:   physAdr = {physFrame[frameTop:6], virtAdr[15:0]};
      default:             physAdr = {physFrame[frameTop:2], virtAdr[11:0]};
    endcase
  end

  assign done        = hitValid & (hitCode == faultPkg::faultNone);
  assign abort       = walkFault | (hitValid & (hitCode != faultPkg::faultNone));
  assign faultStatus = walkFault ? {walkDomain, walkFaultCode} : {domain, hitCode};

  // Walk fault and lookup result never land together
  assert property (@(posedge clk) disable iff (reset) !(done && abort));

endmodule

// ==== hdl/faultPkg.sv ====
package faultPkg;

  // FSR status codes, ARMv5 encoding
  typedef enum logic [3:0] {
    faultNone     = 4'b0000,
    transSection  = 4'b0101,
    transPage     = 4'b0111,
    domainSection = 4'b1001,
    domainPage    = 4'b1011,
    permSection   = 4'b1101,
    permPage      = 4'b1111
  } faultCode;

  // ========================================
  // Register widths
  // ========================================
  localparam int fsrBits = 8;   // Domain in 7:4, code in 3:0
  localparam int farBits = 32;  // Faulting virtual address

endpackage

// ==== hdl/faultRegs.sv ====
`timescale 1ns/10ps

module faultRegs (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         abort,
  input  logic [faultPkg::fsrBits-1:0] faultStatus,
  input  logic [faultPkg::farBits-1:0] virtAdr,
  output logic [faultPkg::fsrBits-1:0] fsr,
  output logic [faultPkg::farBits-1:0] far
);

  // ========================================
  // Fault status and address
  // ========================================
  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      fsr <= '0;
      far <= '0;
    end else if (abort) begin
      fsr <= faultStatus;  // Domain, then status code
      far <= virtAdr;      // Held until next abort
    end
  end

  // Every abort carries a real status code
  assert property (@(posedge clk) disable iff (reset)
    abort |=> fsr[3:0] != faultPkg::faultNone);

endmodule

// ==== hdl/mmuPkg.sv ====
package mmuPkg;

  // ========================================
  // Field widths
  // ========================================
  localparam int vaTagBits     = 22;  // VA 31:10, 1 KB subpage grain
  localparam int ppnBits       = 22;  // PA 31:10
  localparam int domainBits    = 4;
  localparam int apBits        = 2;
  localparam int tableBaseBits = 18;  // TTB 31:14

  // ========================================
  // Descriptor formats
  // ========================================
  // Type field sits in bits 1:0 of every descriptor
  typedef enum logic [1:0] {
    descFault    = 2'b00,
    descCoarse   = 2'b01,  // First level, points at coarse table
    descSection  = 2'b10,  // First level, 1 MB mapping
    descReserved = 2'b11   // Fine table, not supported
  } descType;

  // Second level reuses the same encodings
  localparam descType descLarge = descCoarse;    // 64 KB page
  localparam descType descSmall = descSection;   // 4 KB page
  localparam descType descTiny  = descReserved;  // Treated as fault

  // Mapping size held per TLB entry
  typedef enum logic [1:0] {
    sizeSection = 2'b00,
    sizeLarge   = 2'b01,
    sizeSmall   = 2'b10
  } pageSize;

  // Walker FSM
  typedef enum logic [1:0] {
    walkIdle    = 2'b00,
    fetchFirst  = 2'b01,
    fetchSecond = 2'b10,
    fill        = 2'b11
  } walkState;

endpackage

// ==== hdl/mmuTop.sv ====
`timescale 1ns/10ps

module mmuTop #(
  parameter int tlbEntries = 4
) (
  input  logic                             clk,
  input  logic                             reset,
  input  logic                             request,
  input  logic [31:0]                      virtAdr,
  input  logic                             write,
  input  logic                             privileged,
  input  logic                             mmuEnable,
  input  logic [mmuPkg::tableBaseBits-1:0] tableBase,
  input  logic [31:0]                      domainAccess,
  input  logic                             tlbFlush,
  input  logic                             walkReady,
  input  logic [31:0]                      walkData,
  output logic                             done,
  output logic                             abort,
  output logic [31:0]                      physAdr,
  output logic                             walkReq,
  output logic [31:0]                      walkAdr,
  output logic [faultPkg::fsrBits-1:0]     fsr,
  output logic [faultPkg::farBits-1:0]     far
);

  // Lookup result
  logic                          lookupValid, hit, bypass;
  logic [mmuPkg::ppnBits-1:0]    physFrame;
  mmuPkg::pageSize               size;
  logic [mmuPkg::domainBits-1:0] domain;
  logic [mmuPkg::apBits-1:0]     ap;
  // Walker to TLB and checker
  logic                          walkBusy, walkFault, fillValid;
  faultPkg::faultCode            walkFaultCode;
  logic [mmuPkg::domainBits-1:0] walkDomain, fillDomain;
  logic [mmuPkg::vaTagBits-1:0]  fillTag;
  logic [mmuPkg::ppnBits-1:0]    fillFrame;
  mmuPkg::pageSize               fillSize;
  logic [mmuPkg::apBits-1:0]     fillAp;
  logic [faultPkg::fsrBits-1:0]  faultStatus;

  translationTlb #(.tlbEntries(tlbEntries)) u_lookup (
    .clk, .reset, .request, .virtAdr, .mmuEnable, .walkBusy, .tlbFlush,
    .fillValid, .fillTag, .fillFrame, .fillSize, .fillDomain, .fillAp,
    .lookupValid, .hit, .physFrame, .size, .domain, .ap, .bypass
  );

  tableWalker u_walk (
    .clk, .reset, .lookupValid, .hit, .virtAdr, .tableBase, .walkReady, .walkData,
    .walkReq, .walkAdr, .walkBusy, .walkFault, .walkFaultCode, .walkDomain,
    .fillValid, .fillTag, .fillFrame, .fillSize, .fillDomain, .fillAp
  );

  accessCheck u_check (
    .clk, .reset, .lookupValid, .hit, .bypass, .size, .domain, .ap, .physFrame,
    .virtAdr, .privileged, .write, .domainAccess, .walkFault, .walkFaultCode,
    .walkDomain, .done, .abort, .physAdr, .faultStatus
  );

  faultRegs u_record (
    .clk, .reset, .abort, .faultStatus, .virtAdr, .fsr, .far
  );

endmodule

// ==== hdl/tableWalker.sv ====
`timescale 1ns/10ps

module tableWalker (
  input  logic                             clk,
  input  logic                             reset,
  input  logic                             lookupValid,
  input  logic                             hit,
  input  logic [31:0]                      virtAdr,
  input  logic [mmuPkg::tableBaseBits-1:0] tableBase,
  input  logic                             walkReady,
  input  logic [31:0]                      walkData,
  output logic                             walkReq,
  output logic [31:0]                      walkAdr,
  output logic                             walkBusy,
  output logic                             walkFault,
  output faultPkg::faultCode               walkFaultCode,
  output logic [mmuPkg::domainBits-1:0]    walkDomain,
  output logic                             fillValid,
  output logic [mmuPkg::vaTagBits-1:0]     fillTag,
  output logic [mmuPkg::ppnBits-1:0]       fillFrame,
  output mmuPkg::pageSize                  fillSize,
  output logic [mmuPkg::domainBits-1:0]    fillDomain,
  output logic [mmuPkg::apBits-1:0]        fillAp
);

  mmuPkg::walkState state;
  mmuPkg::descType  descKind;

  // Pick one of four AP fields from a second-level descriptor
  function automatic logic [mmuPkg::apBits-1:0] subpageAp(
    input logic [31:0] desc,
    input logic [1:0]  sel
  );
    case (sel)
      2'b00:   subpageAp = desc[5:4];
      2'b01:   subpageAp = desc[7:6];
      2'b10:   subpageAp = desc[9:8];
      default: subpageAp = desc[11:10];
    endcase
  endfunction

  assign descKind   = mmuPkg::descType'(walkData[1:0]);
  assign fillValid  = (state == mmuPkg::fill);  // Single fill cycle
  assign walkBusy   = (state != mmuPkg::walkIdle) | walkFault;
  assign walkDomain = fillDomain;               // Latched from first level
  assign fillTag    = virtAdr[31:10];           // CPU holds VA through walk

  // ========================================
  // Walk FSM
  // ========================================
  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      state     <= mmuPkg::walkIdle;
      walkReq   <= 1'b0;
      walkFault <= 1'b0;
    end else begin
      walkFault <= 1'b0;  // Pulse
      case (state)
        mmuPkg::walkIdle: begin
          if (lookupValid && !hit) begin  // TLB miss
            state   <= mmuPkg::fetchFirst;
            walkReq <= 1'b1;
          end
        end
        mmuPkg::fetchFirst: begin
          if (walkReady) begin
            case (descKind)
              mmuPkg::descSection: begin
                state   <= mmuPkg::fill;
                walkReq <= 1'b0;
              end
              mmuPkg::descCoarse: state <= mmuPkg::fetchSecond;  // Request stays up
              mmuPkg::descFault, mmuPkg::descReserved: begin
                state     <= mmuPkg::walkIdle;
                walkReq   <= 1'b0;
                walkFault <= 1'b1;
              end
            endcase
          end
        end
        mmuPkg::fetchSecond: begin
          if (walkReady) begin
            walkReq <= 1'b0;
            case (descKind)
              mmuPkg::descLarge, mmuPkg::descSmall: state <= mmuPkg::fill;
              mmuPkg::descFault, mmuPkg::descTiny: begin
                state     <= mmuPkg::walkIdle;
                walkFault <= 1'b1;
              end
            endcase
          end
        end
        default: state <= mmuPkg::walkIdle;  // Leaving fill
      endcase
    end
  end

  // ========================================
  // Address and entry payload
  // ========================================
  always_ff @(posedge clk) begin
    case (state)
      mmuPkg::walkIdle: walkAdr <= {tableBase, virtAdr[31:20], 2'b00};  // L1 index
      mmuPkg::fetchFirst: begin
        if (walkReady) begin
          walkAdr       <= {walkData[31:10], virtAdr[19:12], 2'b00};  // L2 index
          fillDomain    <= walkData[8:5];
          fillFrame     <= {walkData[31:20], 10'b0};
          fillSize      <= mmuPkg::sizeSection;
          fillAp        <= walkData[11:10];
          walkFaultCode <= faultPkg::transSection;
        end
      end
      mmuPkg::fetchSecond: begin
        if (walkReady) begin
          if (descKind == mmuPkg::descLarge) begin
            fillFrame <= {walkData[31:16], 6'b0};
            fillSize  <= mmuPkg::sizeLarge;
            fillAp    <= subpageAp(walkData, virtAdr[15:14]);  // 16 KB subpage
          end else begin
            fillFrame <= {walkData[31:12], 2'b0};
            fillSize  <= mmuPkg::sizeSmall;
            fillAp    <= subpageAp(walkData, virtAdr[11:10]);  // 1 KB subpage
          end
          walkFaultCode <= faultPkg::transPage;
        end
      end
      default: ;
    endcase
  end

  assert property (@(posedge clk) disable iff (reset)
    walkReq |-> (state == mmuPkg::fetchFirst || state == mmuPkg::fetchSecond));

  // Slow memory only stretches the read
  assert property (@(posedge clk) disable iff (reset)
    walkReq && !walkReady |=> walkReq && $stable(walkAdr));

endmodule

// ==== hdl/translationTlb.sv ====
`timescale 1ns/10ps

module translationTlb #(
  parameter int tlbEntries = 4
) (
  input  logic                             clk,
  input  logic                             reset,
  input  logic                             request,
  input  logic [31:0]                      virtAdr,
  input  logic                             mmuEnable,
  input  logic                             walkBusy,
  input  logic                             tlbFlush,
  input  logic                             fillValid,
  input  logic [mmuPkg::vaTagBits-1:0]     fillTag,
  input  logic [mmuPkg::ppnBits-1:0]       fillFrame,
  input  mmuPkg::pageSize                  fillSize,
  input  logic [mmuPkg::domainBits-1:0]    fillDomain,
  input  logic [mmuPkg::apBits-1:0]        fillAp,
  output logic                             lookupValid,
  output logic                             hit,
  output logic [mmuPkg::ppnBits-1:0]       physFrame,
  output mmuPkg::pageSize                  size,
  output logic [mmuPkg::domainBits-1:0]    domain,
  output logic [mmuPkg::apBits-1:0]        ap,
  output logic                             bypass
);

  localparam int ptrBits = $clog2(tlbEntries);
  localparam int tagTop  = mmuPkg::vaTagBits - 1;

  // ========================================
  // Entry storage
  // ========================================
  logic [tlbEntries-1:0]             entryValid;
  logic [mmuPkg::vaTagBits-1:0]      entryTag    [tlbEntries];
  logic [mmuPkg::ppnBits-1:0]        entryFrame  [tlbEntries];
  mmuPkg::pageSize                   entrySize   [tlbEntries];
  logic [mmuPkg::domainBits-1:0]     entryDomain [tlbEntries];
  logic [mmuPkg::apBits-1:0]         entryAp     [tlbEntries];
  logic [ptrBits-1:0]                fillPtr;     // Round-robin victim
  logic [tlbEntries-1:0]             match;
  logic [ptrBits-1:0]                matchIdx;
  logic                              startLookup;

  // lookupValid doubles as the pending flag
  assign startLookup = request & ~lookupValid & ~walkBusy;

  // Tag compare masked by mapping size
  always_comb begin
    for (int i = 0; i < tlbEntries; i++) begin
      case (entrySize[i])
        mmuPkg::sizeSection: match[i] = entryTag[i][tagTop:10] == virtAdr[31:20];
        mmuPkg::sizeLarge:   match[i] = entryTag[i][tagTop:4] == virtAdr[31:14];
        default:             match[i] = entryTag[i] == virtAdr[31:10];
      endcase
      match[i] = match[i] & entryValid[i];
    end
  end

  // Lowest matching index wins
  always_comb begin
    matchIdx = '0;
    for (int i = tlbEntries - 1; i >= 0; i--) begin
      if (match[i]) matchIdx = ptrBits'(i);
    end
  end

  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      entryValid <= '0;
      fillPtr    <= '0;
    end else if (tlbFlush) begin
      entryValid <= '0;  // Flush beats a same-cycle fill
    end else if (fillValid) begin
      entryValid[fillPtr] <= 1'b1;
      fillPtr             <= fillPtr + 1'b1;  // Wraps, power of two
    end
  end

  always_ff @(posedge clk) begin
    if (fillValid) begin
      entryTag[fillPtr]    <= fillTag;
      entryFrame[fillPtr]  <= fillFrame;
      entrySize[fillPtr]   <= fillSize;
      entryDomain[fillPtr] <= fillDomain;
      entryAp[fillPtr]     <= fillAp;
    end
  end

  // ========================================
  // Registered lookup result
  // ========================================
  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      lookupValid <= 1'b0;
      hit         <= 1'b0;
      bypass      <= 1'b0;
    end else begin
      lookupValid <= startLookup;  // One-cycle pulse
      if (startLookup) begin
        hit    <= ~mmuEnable | (|match);
        bypass <= ~mmuEnable;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (startLookup) begin
      if (!mmuEnable) begin
        physFrame <= virtAdr[31:10];  // Identity map
        size      <= mmuPkg::sizeSmall;
        domain    <= '0;
        ap        <= '0;
      end else begin
        physFrame <= entryFrame[matchIdx];
        size      <= entrySize[matchIdx];
        domain    <= entryDomain[matchIdx];
        ap        <= entryAp[matchIdx];
      end
    end
  end

  // Walker never fills while a lookup result is out
  assert property (@(posedge clk) disable iff (reset) !(fillValid && lookupValid));

endmodule

// ==== run.sh ====
#!/bin/sh
# Build and run the MMU testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f compile.f --top-module mmuBench -o mmuSim
simOut=$(./obj_dir/mmuSim) || true
echo "$simOut"
if echo "$simOut" | grep -qx "No errors"; then
  exit 0
fi
exit 1
